// ==== vid_core_params.svh ====
////////////////////
// widths, register map and video timing of the video core
// include in any file that needs a size or a register number
////////////////////
`ifndef VID_CORE_PARAMS_SVH
`define VID_CORE_PARAMS_SVH

`define VC_WORD_W           16      // cpu register word
`define VC_BYTE_W           8       // bus byte
`define VC_REG_NUM_W        4       // register number bits

`define VC_PAL_DEPTH        16      // palette entries
`define VC_PAL_IDX_W        4
`define VC_RGB_W            12      // 4 bits per gun

`define VC_INTR_W           2
`define VC_FRAME_INTR       0       // v_blank begins
`define VC_LINE_INTR        1       // line compare hit

// register numbers
`define VC_REG_SCRATCH      0
`define VC_REG_LINE_CMP     1
`define VC_REG_PAL_ADDR     2
`define VC_REG_PAL_DATA     3       // auto-increments PAL_ADDR on odd write
`define VC_REG_INT_CTRL     4       // even byte mask, odd byte status/clear
`define VC_REG_STATUS       5       // read only blank flags

`define VC_H_VISIBLE        16
`define VC_H_SYNC_START     18
`define VC_H_SYNC_END       20
`define VC_H_TOTAL          24
`define VC_V_VISIBLE        8
`define VC_V_SYNC_START     9
`define VC_V_SYNC_END       10
`define VC_V_TOTAL          12
`define VC_H_CNT_W          5
`define VC_V_CNT_W          4

`define VC_OUT_DELAY        2       // counter state to output ports

`endif

// ==== vid_core_pkg.sv ====
////////////////////
// types shared by the video core units
// reference as vid_core_pkg::name
////////////////////
`include "vid_core_params.svh"

package vid_core_pkg;

typedef logic [`VC_WORD_W-1:0]      word_t;     // cpu register word
typedef logic [`VC_BYTE_W-1:0]      byte_t;     // bus byte
typedef logic [`VC_REG_NUM_W-1:0]   reg_num_t;
typedef logic [`VC_PAL_IDX_W-1:0]   pal_idx_t;
typedef logic [`VC_RGB_W-1:0]       rgb_t;      // red in top nibble
typedef logic [`VC_H_CNT_W-1:0]     hcount_t;
typedef logic [`VC_V_CNT_W-1:0]     vcount_t;
typedef logic [`VC_INTR_W-1:0]      intr_t;     // bit 0 frame, bit 1 line

// bus side palette port
typedef struct packed {
    logic       wr;         // one cycle write strobe
    pal_idx_t   idx;        // write and read entry
    rgb_t       color;      // write colour
} pal_req_t;

// sync pulses are active low
typedef struct packed {
    logic       hsync;
    logic       vsync;
    logic       de;         // display enable
} sync_t;

// v_blank in bit 1, h_blank in bit 0
typedef struct packed {
    logic       v_blank;
    logic       h_blank;
} blank_t;

typedef enum logic [1:0] {
    BUS_IDLE,               // waiting for cs_n low
    BUS_ACCESS,             // read byte captured here
    BUS_HOLD                // waiting for cs_n high
} bus_phase_e;

endpackage

// ==== bus_regs.sv ====
////////////////////
// cpu byte bus register interface
// even byte is latched, odd byte commits the word
////////////////////
`include "vid_core_params.svh"

module bus_regs(
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        bus_cs_n_i,     // chip select, active low
    input  logic                        bus_rd_nwr_i,   // 1 read, 0 write
    input  vid_core_pkg::reg_num_t      bus_reg_num_i,
    input  logic                        bus_bytesel_i,  // 0 even (high), 1 odd (low)
    input  vid_core_pkg::byte_t         bus_data_i,
    input  vid_core_pkg::rgb_t          pal_rd_data_i,  // entry at pal_req_o.idx
    input  vid_core_pkg::blank_t        blank_i,
    input  vid_core_pkg::intr_t         intr_status_i,
    output vid_core_pkg::byte_t         bus_data_o,
    output vid_core_pkg::pal_req_t      pal_req_o,
    output vid_core_pkg::vcount_t       line_cmp_o,
    output vid_core_pkg::intr_t         intr_mask_o,
    output vid_core_pkg::intr_t         intr_clear_o
);

localparam vid_core_pkg::reg_num_t REG_SCRATCH  = `VC_REG_SCRATCH;
localparam vid_core_pkg::reg_num_t REG_LINE_CMP = `VC_REG_LINE_CMP;
localparam vid_core_pkg::reg_num_t REG_PAL_ADDR = `VC_REG_PAL_ADDR;
localparam vid_core_pkg::reg_num_t REG_PAL_DATA = `VC_REG_PAL_DATA;
localparam vid_core_pkg::reg_num_t REG_INT_CTRL = `VC_REG_INT_CTRL;
localparam vid_core_pkg::reg_num_t REG_STATUS   = `VC_REG_STATUS;

vid_core_pkg::bus_phase_e   phase;
logic                       cs_n_s1;            // two flop synchronizers
logic                       cs_n_s2;
logic                       rd_nwr_s1;
logic                       rd_nwr_s2;
vid_core_pkg::reg_num_t     reg_num_s1;
vid_core_pkg::reg_num_t     reg_num_s2;
logic                       bytesel_s1;
logic                       bytesel_s2;
vid_core_pkg::byte_t        data_s1;
vid_core_pkg::byte_t        data_s2;

logic                       wr_strobe;          // one cycle per write access
vid_core_pkg::byte_t        even_latch;         // high byte waiting for odd write
vid_core_pkg::word_t        wr_word;
vid_core_pkg::word_t        rd_word;
vid_core_pkg::word_t        scratch;
vid_core_pkg::pal_idx_t     pal_addr;
logic                       pal_wr;
vid_core_pkg::pal_idx_t     pal_idx_q;          // pal_addr one cycle late
vid_core_pkg::rgb_t         pal_color_q;

always_ff @(posedge clk) begin
    if (reset_i) begin
        cs_n_s1 <= 1'b1;                        // so first low is a new access
        cs_n_s2 <= 1'b1;
    end else begin
        cs_n_s1 <= bus_cs_n_i;
        cs_n_s2 <= cs_n_s1;
    end
end

always_ff @(posedge clk) begin
    rd_nwr_s1  <= bus_rd_nwr_i;
    rd_nwr_s2  <= rd_nwr_s1;
    reg_num_s1 <= bus_reg_num_i;
    reg_num_s2 <= reg_num_s1;
    bytesel_s1 <= bus_bytesel_i;
    bytesel_s2 <= bytesel_s1;
    data_s1    <= bus_data_i;
    data_s2    <= data_s1;
end

// IDLE is only re-entered with cs_n high, so low here is a falling edge
assign wr_strobe = (phase == vid_core_pkg::BUS_IDLE) && !cs_n_s2 && !rd_nwr_s2;
assign wr_word   = {even_latch, data_s2};
assign pal_req_o = '{wr: pal_wr, idx: pal_idx_q, color: pal_color_q};

always_ff @(posedge clk) begin
    if (reset_i) begin
        phase        <= vid_core_pkg::BUS_IDLE;
        scratch      <= '0;
        line_cmp_o   <= '0;
        pal_addr     <= '0;
        pal_wr       <= 1'b0;
        intr_mask_o  <= '0;
        intr_clear_o <= '0;
    end else begin
        pal_wr       <= 1'b0;                   // strobes last one cycle
        intr_clear_o <= '0;
        case (phase)
            vid_core_pkg::BUS_IDLE:   if (!cs_n_s2) phase <= vid_core_pkg::BUS_ACCESS;
            vid_core_pkg::BUS_ACCESS: phase <= vid_core_pkg::BUS_HOLD;
            vid_core_pkg::BUS_HOLD:   if (cs_n_s2) phase <= vid_core_pkg::BUS_IDLE;
            default:                  phase <= vid_core_pkg::BUS_IDLE;
        endcase
        if (wr_strobe && !bytesel_s2 && reg_num_s2 == REG_INT_CTRL) begin
            intr_mask_o <= data_s2[`VC_INTR_W-1:0];
        end
        if (wr_strobe && bytesel_s2) begin
            case (reg_num_s2)
                REG_SCRATCH:  scratch    <= wr_word;
                REG_LINE_CMP: line_cmp_o <= wr_word[`VC_V_CNT_W-1:0];
                REG_PAL_ADDR: pal_addr   <= wr_word[`VC_PAL_IDX_W-1:0];
                REG_PAL_DATA: begin
                    pal_wr   <= 1'b1;
                    pal_addr <= pal_addr + 1'b1;            // wraps at 16
                end
                REG_INT_CTRL: intr_clear_o <= data_s2[`VC_INTR_W-1:0];   // odd byte alone
                default: ;                                  // STATUS read only
            endcase
        end
    end
end

always_ff @(posedge clk) begin
    if (wr_strobe && !bytesel_s2) begin
        even_latch <= data_s2;
    end
    pal_idx_q   <= pal_addr;                    // old address on the increment edge
    pal_color_q <= wr_word[`VC_RGB_W-1:0];
end

always_comb begin
    case (reg_num_s2)
        REG_SCRATCH:  rd_word = scratch;
        REG_LINE_CMP: rd_word = vid_core_pkg::word_t'(line_cmp_o);
        REG_PAL_ADDR: rd_word = vid_core_pkg::word_t'(pal_addr);
        REG_PAL_DATA: rd_word = vid_core_pkg::word_t'(pal_rd_data_i);
        REG_INT_CTRL: rd_word = {vid_core_pkg::byte_t'(intr_mask_o),
                                 vid_core_pkg::byte_t'(intr_status_i)};
        REG_STATUS:   rd_word = vid_core_pkg::word_t'(blank_i);     // odd bits 1:0
        default:      rd_word = '0;
    endcase
end

// read byte lands on the fourth edge after cs_n falls
always_ff @(posedge clk) begin
    if (phase == vid_core_pkg::BUS_ACCESS && rd_nwr_s2) begin
        bus_data_o <= bytesel_s2 ? rd_word[`VC_BYTE_W-1:0] : rd_word[`VC_WORD_W-1:`VC_BYTE_W];
    end
end

endmodule

// ==== intr_ctrl.sv ====
////////////////////
// interrupt pending status and bus interrupt pulse
////////////////////
`include "vid_core_params.svh"

module intr_ctrl(
    input  logic                    clk,
    input  logic                    reset_i,
    input  vid_core_pkg::intr_t     intr_trigger_i,     // one cycle source pulses
    input  vid_core_pkg::intr_t     intr_mask_i,        // 1 enables a source
    input  vid_core_pkg::intr_t     intr_clear_i,       // one cycle clear strobe
    output vid_core_pkg::intr_t     intr_status_o,      // pending, mask not applied
    output logic                    bus_intr_o
);

vid_core_pkg::intr_t    new_intr;   // enabled and not yet pending

assign new_intr = intr_trigger_i & intr_mask_i & ~intr_status_o;

always_ff @(posedge clk) begin
    if (reset_i) begin
        bus_intr_o    <= 1'b0;
        intr_status_o <= '0;
    end else begin
        bus_intr_o    <= |new_intr;    // single pulse per new event
        // clear wins over a trigger in the same cycle
        intr_status_o <= (intr_status_o | intr_trigger_i) & ~intr_clear_i;
    end
end

endmodule

// ==== video_timing.sv ====
////////////////////
// horizontal and vertical counters with sync, blank and enable
// outputs are registered from the next count, so they line up with it
////////////////////
`include "vid_core_params.svh"

module video_timing(
    input  logic                    clk,
    input  logic                    reset_i,
    input  vid_core_pkg::vcount_t   line_cmp_i,     // line for the compare interrupt
    output vid_core_pkg::pal_idx_t  pal_idx_o,      // stand-in for the vram fetch
    output vid_core_pkg::sync_t     sync_o,
    output vid_core_pkg::blank_t    blank_o,
    output vid_core_pkg::intr_t     intr_trigger_o  // one cycle pulses
);

localparam vid_core_pkg::hcount_t H_VISIBLE    = `VC_H_VISIBLE;
localparam vid_core_pkg::hcount_t H_SYNC_START = `VC_H_SYNC_START;
localparam vid_core_pkg::hcount_t H_SYNC_END   = `VC_H_SYNC_END;
localparam vid_core_pkg::hcount_t H_LAST       = `VC_H_TOTAL - 1;
localparam vid_core_pkg::vcount_t V_VISIBLE    = `VC_V_VISIBLE;
localparam vid_core_pkg::vcount_t V_SYNC_START = `VC_V_SYNC_START;
localparam vid_core_pkg::vcount_t V_SYNC_END   = `VC_V_SYNC_END;
localparam vid_core_pkg::vcount_t V_LAST       = `VC_V_TOTAL - 1;

vid_core_pkg::hcount_t  h_cnt;
vid_core_pkg::vcount_t  v_cnt;
vid_core_pkg::hcount_t  h_next;
vid_core_pkg::vcount_t  v_next;
logic                   h_vis;      // of the next count
logic                   v_vis;
logic                   col_zero;

always_comb begin
    h_next = (h_cnt == H_LAST) ? '0 : h_cnt + 1'b1;
    v_next = v_cnt;
    if (h_cnt == H_LAST) begin
        v_next = (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;     // end of line
    end
    h_vis    = (h_next < H_VISIBLE);
    v_vis    = (v_next < V_VISIBLE);
    col_zero = (h_next == '0);
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        h_cnt          <= '0;
        v_cnt          <= '0;
        pal_idx_o      <= '0;
        sync_o         <= '{hsync: 1'b1, vsync: 1'b1, de: 1'b1};    // count 0 is visible
        blank_o        <= '0;
        intr_trigger_o <= '0;
    end else begin
        h_cnt          <= h_next;
        v_cnt          <= v_next;
        pal_idx_o      <= h_next[`VC_PAL_IDX_W-1:0] + v_next;
        sync_o.hsync   <= !(h_next >= H_SYNC_START && h_next < H_SYNC_END);  // active low
        sync_o.vsync   <= !(v_next >= V_SYNC_START && v_next < V_SYNC_END);
        sync_o.de      <= h_vis && v_vis;
        blank_o        <= '{v_blank: !v_vis, h_blank: !h_vis};
        intr_trigger_o[`VC_FRAME_INTR] <= col_zero && (v_next == V_VISIBLE);   // v_blank begins
        intr_trigger_o[`VC_LINE_INTR]  <= col_zero && (v_next == line_cmp_i);
    end
end

endmodule

// ==== color_out.sv ====
////////////////////
// colour palette and the aligned video output stage
// bus port writes and reads, video port looks up pixel colour
////////////////////
`include "vid_core_params.svh"

module color_out(
    input  logic                        clk,
    input  logic                        reset_i,
    input  vid_core_pkg::pal_req_t      pal_req_i,      // bus side palette port
    input  vid_core_pkg::pal_idx_t      pal_idx_i,      // pixel index from timing
    input  vid_core_pkg::sync_t         sync_i,         // aligned with pal_idx_i
    output vid_core_pkg::rgb_t          pal_rd_data_o,  // one cycle after idx
    output logic [`VC_RGB_W/3-1:0]      red_o,
    output logic [`VC_RGB_W/3-1:0]      green_o,
    output logic [`VC_RGB_W/3-1:0]      blue_o,
    output logic                        hsync_o,
    output logic                        vsync_o,
    output logic                        dv_de_o
);

vid_core_pkg::rgb_t     pal_mem [`VC_PAL_DEPTH];   // contents survive reset
vid_core_pkg::rgb_t     look_rgb;                   // video lookup result
vid_core_pkg::sync_t    sync_d [`VC_OUT_DELAY];     // sync delay line

// palette, one write port and two read ports
always_ff @(posedge clk) begin
    if (pal_req_i.wr) begin
        pal_mem[pal_req_i.idx] <= pal_req_i.color;
    end
    pal_rd_data_o <= pal_mem[pal_req_i.idx];
    look_rgb      <= pal_mem[pal_idx_i];
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        for (int i = 0; i < `VC_OUT_DELAY; i++) begin
            sync_d[i] <= '{hsync: 1'b1, vsync: 1'b1, de: 1'b0};    // syncs idle high
        end
        {red_o, green_o, blue_o} <= '0;
    end else begin
        sync_d[0] <= sync_i;                    // alongside the lookup
        for (int i = 1; i < `VC_OUT_DELAY; i++) begin
            sync_d[i] <= sync_d[i-1];
        end
        // black outside the visible area
        if (sync_d[0].de) begin
            {red_o, green_o, blue_o} <= look_rgb;
        end else begin
            {red_o, green_o, blue_o} <= '0;
        end
    end
end

// last stage leaves with the rgb register
assign hsync_o = sync_d[`VC_OUT_DELAY-1].hsync;
assign vsync_o = sync_d[`VC_OUT_DELAY-1].vsync;
assign dv_de_o = sync_d[`VC_OUT_DELAY-1].de;

endmodule

// ==== vid_core_top.sv ====
////////////////////
// video core top, cpu bus in and video out
////////////////////
`include "vid_core_params.svh"

module vid_core_top(
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        bus_cs_n_i,     // active low
    input  logic                        bus_rd_nwr_i,
    input  logic [`VC_REG_NUM_W-1:0]    bus_reg_num_i,
    input  logic                        bus_bytesel_i,
    input  logic [`VC_BYTE_W-1:0]       bus_data_i,
    output logic [`VC_BYTE_W-1:0]       bus_data_o,
    output logic                        bus_intr_o,     // one cycle pulse
    output logic [`VC_RGB_W/3-1:0]      red_o,
    output logic [`VC_RGB_W/3-1:0]      green_o,
    output logic [`VC_RGB_W/3-1:0]      blue_o,
    output logic                        hsync_o,
    output logic                        vsync_o,
    output logic                        dv_de_o
);

logic [`VC_PAL_IDX_W+`VC_RGB_W:0]   pal_req;        // wr, idx, colour
logic [`VC_RGB_W-1:0]               pal_rd_data;
logic [`VC_PAL_IDX_W-1:0]           pal_idx;
logic [2:0]                         sync;           // hsync, vsync, de
logic [1:0]                         blank;          // v_blank, h_blank
logic [`VC_V_CNT_W-1:0]             line_cmp;
logic [`VC_INTR_W-1:0]              intr_trigger;
logic [`VC_INTR_W-1:0]              intr_mask;
logic [`VC_INTR_W-1:0]              intr_clear;
logic [`VC_INTR_W-1:0]              intr_status;

bus_regs bus_regs(
    .clk(clk), .reset_i(reset_i),
    .bus_cs_n_i(bus_cs_n_i), .bus_rd_nwr_i(bus_rd_nwr_i),
    .bus_reg_num_i(bus_reg_num_i), .bus_bytesel_i(bus_bytesel_i),
    .bus_data_i(bus_data_i), .bus_data_o(bus_data_o),
    .pal_rd_data_i(pal_rd_data), .blank_i(blank), .intr_status_i(intr_status),
    .pal_req_o(pal_req), .line_cmp_o(line_cmp),
    .intr_mask_o(intr_mask), .intr_clear_o(intr_clear)
);

intr_ctrl intr_ctrl(
    .clk(clk), .reset_i(reset_i),
    .intr_trigger_i(intr_trigger), .intr_mask_i(intr_mask), .intr_clear_i(intr_clear),
    .intr_status_o(intr_status), .bus_intr_o(bus_intr_o)
);

video_timing video_timing(
    .clk(clk), .reset_i(reset_i), .line_cmp_i(line_cmp),
    .pal_idx_o(pal_idx), .sync_o(sync), .blank_o(blank), .intr_trigger_o(intr_trigger)
);

color_out color_out(
    .clk(clk), .reset_i(reset_i),
    .pal_req_i(pal_req), .pal_idx_i(pal_idx), .sync_i(sync), .pal_rd_data_o(pal_rd_data),
    .red_o(red_o), .green_o(green_o), .blue_o(blue_o),
    .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o)
);

endmodule

// ==== tb_vid_core.sv ====
////////////////////
// directed testbench for the video core
// cpu byte bus tasks, palette and video checks, interrupt checks
////////////////////
`include "vid_core_params.svh"

module tb_vid_core;

timeunit 1ns;
timeprecision 1ps;

localparam int FRAME_CYCLES   = `VC_H_TOTAL * `VC_V_TOTAL;     // 288 clocks per frame
localparam int TIMEOUT_CYCLES = 4 * FRAME_CYCLES + 2000;
localparam int LINE_HIT       = 3;                             // line compare target

localparam vid_core_pkg::reg_num_t REG_SCRATCH  = `VC_REG_SCRATCH;
localparam vid_core_pkg::reg_num_t REG_LINE_CMP = `VC_REG_LINE_CMP;
localparam vid_core_pkg::reg_num_t REG_PAL_ADDR = `VC_REG_PAL_ADDR;
localparam vid_core_pkg::reg_num_t REG_PAL_DATA = `VC_REG_PAL_DATA;
localparam vid_core_pkg::reg_num_t REG_INT_CTRL = `VC_REG_INT_CTRL;
localparam vid_core_pkg::reg_num_t REG_STATUS   = `VC_REG_STATUS;

localparam vid_core_pkg::intr_t FRAME_BIT = 1 << `VC_FRAME_INTR;
localparam vid_core_pkg::intr_t LINE_BIT  = 1 << `VC_LINE_INTR;
localparam vid_core_pkg::byte_t CLEAR_ALL = 8'h03;                 // both sources

logic                       clk = 1'b0;
logic                       reset_i;
logic                       bus_cs_n;
logic                       bus_rd_nwr;
vid_core_pkg::reg_num_t     bus_reg_num;
logic                       bus_bytesel;
vid_core_pkg::byte_t        bus_wdata;
vid_core_pkg::byte_t        bus_rdata;
logic                       bus_intr;
logic [3:0]                 red;
logic [3:0]                 green;
logic [3:0]                 blue;
logic                       hsync;
logic                       vsync;
logic                       dv_de;

integer                     seed = 19848;
int                         errors = 0;
int                         cycles = 0;

vid_core_top DUT(
    .clk(clk), .reset_i(reset_i),
    .bus_cs_n_i(bus_cs_n), .bus_rd_nwr_i(bus_rd_nwr), .bus_reg_num_i(bus_reg_num),
    .bus_bytesel_i(bus_bytesel), .bus_data_i(bus_wdata), .bus_data_o(bus_rdata),
    .bus_intr_o(bus_intr), .red_o(red), .green_o(green), .blue_o(blue),
    .hsync_o(hsync), .vsync_o(vsync), .dv_de_o(dv_de)
);

always #2 clk = ~clk;       // 4 ns period

// watchdog
always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Finished with errors");
        $finish;
    end
end

task automatic check_word(input string name, input vid_core_pkg::word_t exp,
                          input vid_core_pkg::word_t act);
    if (act !== exp) begin
        $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
        errors++;
    end
endtask

task automatic check_rgb(input string name, input vid_core_pkg::rgb_t exp,
                         input vid_core_pkg::rgb_t act);
    if (act !== exp) begin
        $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
        errors++;
    end
endtask

task automatic check_intr(input string name, input vid_core_pkg::intr_t exp,
                          input vid_core_pkg::intr_t act);
    if (act !== exp) begin
        $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
        errors++;
    end
endtask

// one byte access with cs_n low 4 cycles then high 3
task automatic bus_access(input logic rd, input vid_core_pkg::reg_num_t num, input logic sel,
                          input vid_core_pkg::byte_t wdata, output vid_core_pkg::byte_t rdata);
    @(posedge clk);
    bus_cs_n    <= 1'b0;
    bus_rd_nwr  <= rd;
    bus_reg_num <= num;
    bus_bytesel <= sel;
    bus_wdata   <= wdata;
    repeat (4) @(posedge clk);      // read byte valid from this edge
    bus_cs_n    <= 1'b1;
    @(negedge clk);
    rdata = bus_rdata;
    repeat (2) @(posedge clk);
endtask

task automatic bus_write(input vid_core_pkg::reg_num_t num, input logic sel,
                         input vid_core_pkg::byte_t data);
    vid_core_pkg::byte_t unused;
    bus_access(1'b0, num, sel, data, unused);
endtask

task automatic bus_read(input vid_core_pkg::reg_num_t num, input logic sel,
                        output vid_core_pkg::byte_t data);
    bus_access(1'b1, num, sel, '0, data);
endtask

// even (high) byte first and the odd byte commits
task automatic write_word(input vid_core_pkg::reg_num_t num, input vid_core_pkg::word_t data);
    bus_write(num, 1'b0, data[15:8]);
    bus_write(num, 1'b1, data[7:0]);
endtask

task automatic read_word(input vid_core_pkg::reg_num_t num, output vid_core_pkg::word_t data);
    vid_core_pkg::byte_t hi;
    vid_core_pkg::byte_t lo;
    bus_read(num, 1'b0, hi);
    bus_read(num, 1'b1, lo);
    data = {hi, lo};
endtask

// waits up to two frames for a bus interrupt pulse and returns its cycle
task automatic wait_intr(input string name, output int at);
    int  n;
    bit  seen;
    n    = 0;
    seen = 1'b0;
    at   = 0;
    while (!seen && n < 2 * FRAME_CYCLES) begin
        @(negedge clk);
        seen = bus_intr;
        n++;
    end
    if (seen) begin
        at = cycles;
        @(negedge clk);
        if (bus_intr) begin                         // pulse is one cycle wide
            $display("%s: bus interrupt stayed high for more than one cycle", name);
            errors++;
        end
    end else begin
        $display("%s: no bus interrupt pulse within %0d cycles", name, n);
        errors++;
    end
endtask

task automatic scratch_rw();
    vid_core_pkg::word_t wr;
    vid_core_pkg::word_t rd;
    for (int i = 0; i < 2; i++) begin
        wr = vid_core_pkg::word_t'($random(seed));
        write_word(REG_SCRATCH, wr);
        read_word(REG_SCRATCH, rd);
        check_word("scratch_round_trip", wr, rd);
    end
    bus_write(REG_SCRATCH, 1'b0, ~wr[15:8]);       // even byte alone, no commit
    read_word(REG_SCRATCH, rd);
    check_word("scratch_even_only", wr, rd);
endtask

task automatic palette_rw();
    vid_core_pkg::rgb_t     colors [`VC_PAL_DEPTH];
    vid_core_pkg::word_t    wr;
    vid_core_pkg::word_t    rd;
    write_word(REG_PAL_ADDR, '0);
    for (int i = 0; i < `VC_PAL_DEPTH; i++) begin
        wr        = vid_core_pkg::word_t'($random(seed));  // top nibble not stored
        colors[i] = wr[`VC_RGB_W-1:0];
        write_word(REG_PAL_DATA, wr);               // address steps by one
    end
    read_word(REG_PAL_ADDR, rd);
    check_word("pal_addr_wrap", '0, rd);            // 16 steps wrap back to 0
    for (int i = 0; i < `VC_PAL_DEPTH; i++) begin
        bus_write(REG_PAL_ADDR, 1'b1, vid_core_pkg::byte_t'(i));   // odd byte holds the index
        read_word(REG_PAL_DATA, rd);
        check_rgb("palette_read", colors[i], vid_core_pkg::rgb_t'(rd));
        check_word("palette_high", '0, rd & 16'hf000);
    end
endtask

task automatic video_frame();
    vid_core_pkg::rgb_t color;
    vid_core_pkg::rgb_t exp;
    int                 run;
    int                 lines;
    int                 guard;
    int                 hs_pulses;
    int                 hs_low;
    logic               prev_de;
    logic               prev_vs;
    logic               prev_hs;
    bit                 done;
    color = vid_core_pkg::rgb_t'($random(seed));
    write_word(REG_PAL_ADDR, '0);
    for (int i = 0; i < `VC_PAL_DEPTH; i++) begin
        write_word(REG_PAL_DATA, vid_core_pkg::word_t'(color));
    end
    prev_vs = 1'b0;
    done    = 1'b0;
    guard   = 0;
    while (!done && guard < 2 * FRAME_CYCLES) begin   // find start of a vsync pulse
        @(negedge clk);
        done    = prev_vs && !vsync;
        prev_vs = vsync;
        guard++;
    end
    if (!done) begin
        $display("video: vsync pulse never started");
        errors++;
    end else begin
        run       = 0;
        lines     = 0;
        hs_pulses = 0;
        hs_low    = 0;
        prev_de   = 1'b0;
        prev_hs   = 1'b1;                               // column 0 is outside hsync
        done      = 1'b0;
        guard     = 0;
        while (!done && guard < 2 * FRAME_CYCLES) begin   // up to the next vsync pulse
            @(negedge clk);
            exp = dv_de ? color : vid_core_pkg::rgb_t'(0);    // black when blanked
            check_rgb("video_pixel", exp, {red, green, blue});
            if (dv_de) begin
                run++;
            end else if (prev_de) begin                     // end of a visible line
                check_word("line_width", `VC_H_VISIBLE, vid_core_pkg::word_t'(run));
                run = 0;
                lines++;
            end
            if (!hsync) begin
                hs_low++;
            end
            if (prev_hs && !hsync) begin                    // one hsync pulse per line
                hs_pulses++;
            end
            done    = prev_vs && !vsync;
            prev_de = dv_de;
            prev_vs = vsync;
            prev_hs = hsync;
            guard++;
        end
        check_word("visible_lines", `VC_V_VISIBLE, vid_core_pkg::word_t'(lines));
        check_word("frame_length", vid_core_pkg::word_t'(FRAME_CYCLES),
                   vid_core_pkg::word_t'(guard));
        check_word("hsync_pulses", `VC_V_TOTAL, vid_core_pkg::word_t'(hs_pulses));
        check_word("hsync_width",
                   vid_core_pkg::word_t'(`VC_V_TOTAL * (`VC_H_SYNC_END - `VC_H_SYNC_START)),
                   vid_core_pkg::word_t'(hs_low));
    end
endtask

task automatic frame_intr();
    vid_core_pkg::byte_t    rd;
    int                     t_first;
    int                     t_next;
    bus_write(REG_INT_CTRL, 1'b0, vid_core_pkg::byte_t'(FRAME_BIT));   // mask before clear
    bus_write(REG_INT_CTRL, 1'b1, CLEAR_ALL);
    wait_intr("frame_intr", t_first);
    bus_read(REG_INT_CTRL, 1'b1, rd);
    check_intr("frame_pending", FRAME_BIT, vid_core_pkg::intr_t'(rd) & FRAME_BIT);
    bus_write(REG_INT_CTRL, 1'b1, vid_core_pkg::byte_t'(FRAME_BIT));
    bus_read(REG_INT_CTRL, 1'b1, rd);
    check_intr("frame_cleared", '0, vid_core_pkg::intr_t'(rd) & FRAME_BIT);
    wait_intr("frame_intr_next", t_next);
    check_word("frame_period", FRAME_CYCLES, vid_core_pkg::word_t'(t_next - t_first));
    bus_read(REG_INT_CTRL, 1'b1, rd);
    check_intr("frame_pending_next", FRAME_BIT, vid_core_pkg::intr_t'(rd) & FRAME_BIT);
endtask

task automatic mask_line_intr();
    vid_core_pkg::byte_t    rd;
    int                     pulses;
    int                     t_hit;
    int                     t_frame;
    bus_write(REG_INT_CTRL, 1'b0, 8'h00);           // all sources masked
    bus_write(REG_INT_CTRL, 1'b1, CLEAR_ALL);
    pulses = 0;
    for (int i = 0; i < FRAME_CYCLES + 4; i++) begin    // covers one frame trigger
        @(negedge clk);
        if (bus_intr) begin
            pulses++;
        end
    end
    check_word("masked_pulses", '0, vid_core_pkg::word_t'(pulses));
    bus_read(REG_INT_CTRL, 1'b1, rd);
    check_intr("masked_status", FRAME_BIT, vid_core_pkg::intr_t'(rd) & FRAME_BIT);
    // line compare on line 3
    write_word(REG_LINE_CMP, vid_core_pkg::word_t'(LINE_HIT));
    bus_write(REG_INT_CTRL, 1'b1, CLEAR_ALL);
    bus_write(REG_INT_CTRL, 1'b0, vid_core_pkg::byte_t'(LINE_BIT));
    bus_write(REG_INT_CTRL, 1'b1, CLEAR_ALL);       // drops a hit landing before the mask
    wait_intr("line_intr", t_hit);
    bus_read(REG_INT_CTRL, 1'b1, rd);
    check_intr("line_status", LINE_BIT, vid_core_pkg::intr_t'(rd) & LINE_BIT);
    // v_blank just after frame start
    bus_write(REG_INT_CTRL, 1'b0, vid_core_pkg::byte_t'(FRAME_BIT));
    bus_write(REG_INT_CTRL, 1'b1, CLEAR_ALL);
    wait_intr("vblank_intr", t_frame);
    check_word("line_position",                     // hit line to v_blank start
               vid_core_pkg::word_t'((`VC_V_VISIBLE - LINE_HIT) * `VC_H_TOTAL),
               vid_core_pkg::word_t'(t_frame - t_hit));
    bus_read(REG_STATUS, 1'b1, rd);
    check_word("vblank_status", 16'h0002, vid_core_pkg::word_t'(rd & 8'h02));  // bit 1 v_blank
endtask

initial begin
    reset_i     = 1'b1;
    bus_cs_n    = 1'b1;     // bus idle
    bus_rd_nwr  = 1'b1;
    bus_reg_num = '0;
    bus_bytesel = 1'b0;
    bus_wdata   = '0;
    repeat (5) @(posedge clk);
    reset_i <= 1'b0;
    scratch_rw();
    palette_rw();
    video_frame();
    frame_intr();
    mask_line_intr();
    repeat (4) @(posedge clk);
    $display("errors: %0d", errors);
    if (errors == 0) begin
        $display("Finished with no errors");
    end else begin
        $display("Finished with errors");
    end
    $finish;
end

endmodule

// ==== vid_core.f ====
+incdir+.
vid_core_pkg.sv
bus_regs.sv
intr_ctrl.sv
video_timing.sv
color_out.sv
vid_core_top.sv
tb_vid_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the video core testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timescale 1ns/1ps --top-module tb_vid_core -f vid_core.f \
    -o tb_vid_core_sim \
    && ./obj_dir/tb_vid_core_sim 2>&1 | tee sim.log
grep -q "^Finished with no errors$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
